//--- src/icache_pkg.sv
package icache_pkg;

   // cache geometry
   localparam int ADDR_W     = 32;
   localparam int WORD_W     = 32;
   localparam int LINE_WORDS = 16;
   localparam int NUM_SETS   = 32;
   localparam int NUM_WAYS   = 2;

   // address field widths
   localparam int TAG_W      = 21;
   localparam int INDEX_W    = 5;
   localparam int WORD_SEL_W = 4;
   localparam int BYTE_OFF_W = 2;

   typedef logic [WORD_W-1:0] word_t;

   // word 0 in the low bits
   typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [INDEX_W-1:0] index_t;

   // byte address as split by the cache
   typedef struct packed {
      tag_t                  tag;
      index_t                index;
      logic [WORD_SEL_W-1:0] word_sel;
      logic [BYTE_OFF_W-1:0] byte_off;
   } addr_t;

   // response to the cpu
   typedef struct packed {
      logic  valid;
      word_t rdata;
   } cpu_rsp_t;

   // refill read request towards memory
   typedef struct packed {
      logic  ce;
      addr_t addr;
   } mem_req_t;

   // one refill word, valid is a single-cycle strobe
   typedef struct packed {
      logic  valid;
      word_t rdata;
   } mem_rsp_t;

   typedef enum logic [1:0] {
      idle   = 2'b00,
      lookup = 2'b01,
      refill = 2'b10
   } state_t;

endpackage

//--- src/icache_ways.sv
`timescale 1ns/10ps

module icache_ways import icache_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  fill_we,
   input  logic  lru_we,
   input  addr_t addr,
   input  line_t fill_line,
   output logic  hit,
   output word_t rdata
);

   // per-way storage, indexed by set
   tag_t                tag_q   [NUM_WAYS][NUM_SETS];
   line_t               data_q  [NUM_WAYS][NUM_SETS];
   logic [NUM_SETS-1:0] valid_q [NUM_WAYS];

   // one bit per set, names the next victim way
   logic [NUM_SETS-1:0] lru_q;

   logic [NUM_WAYS-1:0] way_hit;
   logic [NUM_WAYS-1:0] fill_way;
   word_t               way_word [NUM_WAYS];
   logic                victim;
   logic                lru_next;

   assign victim = lru_q[addr.index];

   // one-hot way select for the line fill
   assign fill_way = victim ? 2'b10 : 2'b01;

   // tag compare and word pick in every way
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_hit[w]  = valid_q[w][addr.index] && (tag_q[w][addr.index] == addr.tag);
         way_word[w] = data_q[w][addr.index][addr.word_sel*WORD_W +: WORD_W];
      end
   end

   assign hit = |way_hit;

   // hit way wins, otherwise the word comes from the refill buffer
   always_comb begin
      rdata = fill_line[addr.word_sel*WORD_W +: WORD_W];
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (way_hit[w]) begin
            rdata = way_word[w];
         end
      end
   end

   // after a hit point at the other way, after a fill at the way not filled
   always_comb begin
      if (way_hit[0]) begin
         lru_next = 1'b1;
      end else if (way_hit[1]) begin
         lru_next = 1'b0;
      end else begin
         lru_next = ~victim;
      end
   end

   // valid and lru bits
   always_ff @(posedge clk) begin
      if (reset) begin
         lru_q <= '0;
         for (int w = 0; w < NUM_WAYS; w++) begin
            valid_q[w] <= '0;
         end
      end else begin
         if (lru_we) begin
            lru_q[addr.index] <= lru_next;
         end
         for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill_we && fill_way[w]) begin
               valid_q[w][addr.index] <= 1'b1;
            end
         end
      end
   end

   // tag and line storage
   always_ff @(posedge clk) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (fill_we && fill_way[w]) begin
            tag_q[w][addr.index]  <= addr.tag;
            data_q[w][addr.index] <= fill_line;
         end
      end
   end

   // a line is only ever filled into the victim, so a tag lives in one way
   a_single_way_hit: assert property (
      @(posedge clk) disable iff (reset)
      $onehot0(way_hit)
   );

endmodule

//--- src/icache_refill.sv
`timescale 1ns/10ps

module icache_refill import icache_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  state_t   state,
   input  addr_t    addr,
   input  mem_rsp_t mem_rsp,
   output mem_req_t mem_req,
   output line_t    fill_line,
   output logic     fill_done
);

   // one extra bit so the count can reach LINE_WORDS
   logic [WORD_SEL_W:0] word_cnt;
   addr_t               req_addr;
   line_t               line_q;
   logic                in_refill;
   logic                take_word;

   assign in_refill = (state == refill);
   assign fill_done = in_refill && (word_cnt == (WORD_SEL_W+1)'(LINE_WORDS));
   assign take_word = in_refill && !fill_done && mem_rsp.valid;

   // word counter
   always_ff @(posedge clk) begin
      if (reset) begin
         word_cnt <= '0;
      end else if (!in_refill) begin
         word_cnt <= '0;
      end else if (take_word) begin
         word_cnt <= word_cnt + 1'b1;
      end
   end

   // line base address outside refill and one word further per strobe
   always_ff @(posedge clk) begin
      if (!in_refill) begin
         req_addr          <= addr;
         req_addr.word_sel <= '0;
         req_addr.byte_off <= '0;
      end else if (take_word) begin
         req_addr <= req_addr + ADDR_W'(4);
      end
   end

   // new word enters at the top so word 0 ends up in the low bits
   always_ff @(posedge clk) begin
      if (take_word) begin
         line_q <= {mem_rsp.rdata, line_q[LINE_WORDS*WORD_W-1:WORD_W]};
      end
   end

   assign fill_line    = line_q;
   assign mem_req.ce   = in_refill && !fill_done;
   assign mem_req.addr = req_addr;

   a_word_cnt_range: assert property (
      @(posedge clk) disable iff (reset)
      word_cnt <= (WORD_SEL_W+1)'(LINE_WORDS)
   );

   // memory only answers an open request
   a_rsp_needs_req: assert property (
      @(posedge clk) disable iff (reset)
      mem_rsp.valid |-> mem_req.ce
   );

endmodule

//--- src/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   flush,
   input  logic   ce,
   input  logic   rdata_ready,
   input  logic   hit,
   input  logic   fill_done,
   output state_t state,
   output logic   rdata_valid,
   output logic   fill_we,
   output logic   lru_we
);

   state_t state_next;
   logic   hit_done;
   logic   miss_done;

   // request ends on these edges
   assign hit_done  = (state == lookup) && hit && rdata_ready;
   assign miss_done = (state == refill) && fill_done && rdata_ready;

   always_comb begin
      state_next = state;
      case (state)
         idle: begin
            if (ce) begin
               state_next = lookup;
            end
         end
         lookup: begin
            if (!hit) begin
               state_next = refill;
            end else if (rdata_ready) begin
               state_next = idle;
            end
         end
         refill: begin
            if (miss_done) begin
               state_next = idle;
            end
         end
         default: begin
            state_next = idle;
         end
      endcase
      // flush drops whatever is in progress
      if (flush) begin
         state_next = idle;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
      end else begin
         state <= state_next;
      end
   end

   assign rdata_valid = ((state == lookup) && hit) || ((state == refill) && fill_done);

   // array strobes, held back when the request is flushed
   assign fill_we = miss_done && !flush;
   assign lru_we  = (hit_done || miss_done) && !flush;

   a_no_valid_in_idle: assert property (
      @(posedge clk) disable iff (reset)
      (state == idle) |-> !rdata_valid
   );

   a_fill_in_refill: assert property (
      @(posedge clk) disable iff (reset)
      fill_we |-> (state == refill)
   );

endmodule

//--- src/icache_top.sv
`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     flush,

   // cpu side
   input  logic     ce,
   input  addr_t    addr,
   input  logic     rdata_ready,
   output cpu_rsp_t cpu_rsp,

   // memory side
   output mem_req_t mem_req,
   input  mem_rsp_t mem_rsp
);

   state_t state;
   logic   hit;
   logic   rdata_valid;
   word_t  rdata;
   logic   fill_we;
   logic   lru_we;
   line_t  fill_line;
   logic   fill_done;

   icache_ctrl i_ctrl (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .ce          (ce),
      .rdata_ready (rdata_ready),
      .hit         (hit),
      .fill_done   (fill_done),
      .state       (state),
      .rdata_valid (rdata_valid),
      .fill_we     (fill_we),
      .lru_we      (lru_we)
   );

   icache_ways i_ways (
      .clk       (clk),
      .reset     (reset),
      .fill_we   (fill_we),
      .lru_we    (lru_we),
      .addr      (addr),
      .fill_line (fill_line),
      .hit       (hit),
      .rdata     (rdata)
   );

   // line buffer and memory address for misses
   icache_refill i_refill (
      .clk       (clk),
      .reset     (reset),
      .state     (state),
      .addr      (addr),
      .mem_rsp   (mem_rsp),
      .mem_req   (mem_req),
      .fill_line (fill_line),
      .fill_done (fill_done)
   );

   assign cpu_rsp = {rdata_valid, rdata};

endmodule

//--- bench/tb_icache.sv
`timescale 1ns/10ps

module tb_icache import icache_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 5000;

   logic     clk = 1'b0;
   logic     reset;
   logic     flush;
   logic     ce;
   addr_t    addr;
   logic     rdata_ready;
   cpu_rsp_t cpu_rsp;
   mem_req_t mem_req;
   mem_rsp_t mem_rsp = '0;

   // memory model state
   logic [31:0] rnd_state = 32'h1507ea78;
   logic [1:0]  gap = 2'd0;
   word_t       req_log [$];
   int          cycles = 0;

   icache_top i_dut (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .ce          (ce),
      .addr        (addr),
      .rdata_ready (rdata_ready),
      .cpu_rsp     (cpu_rsp),
      .mem_req     (mem_req),
      .mem_rsp     (mem_rsp)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      assert (actual === expected)
      else stop_with_error($sformatf("[ERROR] %s expected %h got %h", name, expected, actual));
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      assert (actual === expected)
      else stop_with_error($sformatf("[ERROR] %s expected %h got %h", name, expected, actual));
   endtask

   // memory answers the current refill address with its inverse after a random gap
   always @(posedge clk) begin
      if (reset) begin
         mem_rsp <= '0;
         gap     <= 2'd0;
      end else if (mem_rsp.valid) begin
         // strobe lasts one cycle, the address moves on at this edge
         mem_rsp.valid <= 1'b0;
      end else if (mem_req.ce && !flush) begin
         if (gap == 2'd0) begin
            mem_rsp.valid <= 1'b1;
            mem_rsp.rdata <= ~word_t'(mem_req.addr);
            req_log.push_back(word_t'(mem_req.addr));
            rnd_state = next_random(rnd_state);
            gap       <= rnd_state[1:0];
         end else begin
            gap <= gap - 2'd1;
         end
      end
   end

   // run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         stop_with_error("timeout: the tests did not finish within the cycle limit");
      end
   end

   // one cpu read, hold > 0 keeps rdata_ready low for that many cycles of valid data
   task automatic read_check(input word_t a, input logic expect_hit, input int hold);
      int    log_start;
      word_t held;
      word_t base;
      log_start = req_log.size();
      base      = a & ~32'h3f;
      @(posedge clk);
      ce          <= 1'b1;
      addr        <= a;
      rdata_ready <= (hold == 0);
      @(posedge clk);
      ce <= 1'b0;
      // first cycle in lookup
      @(negedge clk);
      check_bit("rdata_valid", expect_hit, cpu_rsp.valid);
      check_bit("mem_req.ce", 1'b0, mem_req.ce);
      while (!cpu_rsp.valid) begin
         @(negedge clk);
      end
      check_word("rdata", ~(a & ~32'h3), cpu_rsp.rdata);
      if (expect_hit) begin
         check_word("refill word count", 0, req_log.size() - log_start);
      end else begin
         check_word("refill word count", LINE_WORDS, req_log.size() - log_start);
         for (int i = 0; i < LINE_WORDS; i++) begin
            check_word("mem_req.addr", base + word_t'(4 * i), req_log[log_start + i]);
         end
      end
      held = cpu_rsp.rdata;
      for (int i = 0; i < hold; i++) begin
         @(negedge clk);
         check_bit("rdata_valid", 1'b1, cpu_rsp.valid);
         check_word("rdata", held, cpu_rsp.rdata);
         check_bit("mem_req.ce", 1'b0, mem_req.ce);
      end
      if (hold > 0) begin
         @(posedge clk);
         rdata_ready <= 1'b1;
         @(negedge clk);
         check_bit("rdata_valid", 1'b1, cpu_rsp.valid);
         check_word("rdata", held, cpu_rsp.rdata);
      end
      // accepting edge, back in idle afterwards
      @(posedge clk);
      @(negedge clk);
      check_bit("rdata_valid", 1'b0, cpu_rsp.valid);
   endtask

   task automatic reset_and_first_miss_check();
      @(negedge clk);
      check_bit("rdata_valid", 1'b0, cpu_rsp.valid);
      check_bit("mem_req.ce", 1'b0, mem_req.ce);
      // middle of a line, refill still starts at the line base
      read_check(32'h0000_2094, 1'b0, 0);
   endtask

   task automatic hit_path_check();
      for (int w = 0; w < LINE_WORDS; w++) begin
         read_check(32'h0000_2080 + word_t'(4 * w), 1'b1, 0);
      end
   endtask

   task automatic lru_check();
      word_t a;
      word_t b;
      word_t c;
      // same set, three different tags
      a = 32'h0000_1040;
      b = a + 32'h0000_0800;
      c = a + 32'h0000_1000;
      read_check(a, 1'b0, 0);
      read_check(b, 1'b0, 0);
      read_check(a + 32'h8, 1'b1, 0);
      read_check(c, 1'b0, 0);
      read_check(a + 32'h3c, 1'b1, 0);
      read_check(b + 32'h4, 1'b0, 0);
   endtask

   task automatic back_pressure_check();
      read_check(32'h0000_20a8, 1'b1, 5);
      read_check(32'h0000_3124, 1'b0, 6);
   endtask

   task automatic flush_check();
      word_t a;
      int    log_start;
      a         = 32'h0000_41b0;
      log_start = req_log.size();
      @(posedge clk);
      ce          <= 1'b1;
      addr        <= a;
      rdata_ready <= 1'b1;
      @(posedge clk);
      ce <= 1'b0;
      // part of the line has arrived
      while (req_log.size() < log_start + 5) begin
         @(negedge clk);
      end
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      @(negedge clk);
      check_bit("mem_req.ce", 1'b0, mem_req.ce);
      check_bit("rdata_valid", 1'b0, cpu_rsp.valid);
      read_check(a, 1'b0, 0);
   endtask

   initial begin
      reset       = 1'b1;
      flush       = 1'b0;
      ce          = 1'b0;
      addr        = '0;
      rdata_ready = 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      reset_and_first_miss_check();
      hit_path_check();
      lru_check();
      back_pressure_check();
      flush_check();

      repeat (2) @(posedge clk);
      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- icache_top.f
src/icache_pkg.sv
src/icache_ways.sv
src/icache_refill.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/tb_icache.sv

//--- run.sh
#!/bin/sh
# compile the icache testbench with Verilator and run it
# the exit status is the simulator's, non-zero on failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_icache \
   -Mdir obj_dir \
   -f icache_top.f \
   && ./obj_dir/Vtb_icache \
   || { echo "icache simulation did not pass"; exit 1; }
